// File: backend_pkg.sv
package backend_pkg;

    parameter int xlen = 64;
    parameter int lreg_w = 5;

    // cache index sits just above the byte offset inside a 64-bit word
    parameter int mem_index_w = 19;
    parameter int word_offset_w = 3;

    typedef enum logic [3:0] {
        alu_none = 4'd0,        // memory-only micro-op
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_and  = 4'd3,
        alu_or   = 4'd4,
        alu_xor  = 4'd5,
        alu_slt  = 4'd6,
        alu_sltu = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } ls_size_t;

    // lsu handshake states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_wait = 2'd2
    } lsu_state_t;

endpackage

// File: mem_stage_if.sv
`timescale 1ns/1ps

interface mem_stage_if import backend_pkg::*; #(
    parameter int XLEN = xlen
) ();

    logic              valid;
    logic [lreg_w-1:0] rd;
    logic              need_to_wb;
    alu_op_t           alu_op;
    logic              is_load;
    logic              is_store;
    logic              is_unsigned;
    ls_size_t          ls_size;
    logic [XLEN-1:0]   src2;        // store data
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   ls_address;

    modport producer (
        output valid, rd, need_to_wb, alu_op, is_load, is_store, is_unsigned,
        output ls_size, src2, alu_result, ls_address
    );

    modport lsu (input valid, is_load, is_store, ls_address);

    modport align (input ls_size, is_unsigned, ls_address, src2);

    modport wb (input valid, rd, need_to_wb, alu_op, is_load, alu_result);

endinterface

// File: alu_unit.sv
`timescale 1ns/1ps

module alu_unit import backend_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  logic [XLEN-1:0] imm,
    input  logic            is_imm,
    input  alu_op_t         alu_op,
    output logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] ls_address
);

    localparam int shamt_w = $clog2(XLEN);

    logic [XLEN-1:0]    op2;
    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign op2   = is_imm ? imm : src2;
    assign shamt = op2[shamt_w-1:0];

    assign lt_signed   = $signed(src1) < $signed(op2);
    assign lt_unsigned = src1 < op2;

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = src1 + op2;
            end
            alu_sub: begin
                alu_result = src1 - op2;
            end
            alu_and: begin
                alu_result = src1 & op2;
            end
            alu_or: begin
                alu_result = src1 | op2;
            end
            alu_xor: begin
                alu_result = src1 ^ op2;
            end
            alu_slt: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_sll: begin
                alu_result = src1 << shamt;
            end
            alu_srl: begin
                alu_result = src1 >> shamt;
            end
            alu_sra: begin
                alu_result = $unsigned($signed(src1) >>> shamt);
            end
            default: begin
                alu_result = '0;    // alu_none, loads and stores
            end
        endcase
    end

    // address adder runs regardless of op
    assign ls_address = src1 + imm;

endmodule

// File: stage_reg.sv
`timescale 1ns/1ps

module stage_reg import backend_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              stall,
    input  logic              pipeval,
    input  logic [lreg_w-1:0] rd,
    input  logic              need_to_wb,
    input  alu_op_t           alu_op,
    input  logic              is_load,
    input  logic              is_store,
    input  logic              is_unsigned,
    input  ls_size_t          ls_size,
    input  logic [XLEN-1:0]   src2,
    input  logic [XLEN-1:0]   alu_result,
    input  logic [XLEN-1:0]   ls_address,
    mem_stage_if.producer     mem
);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem.valid <= 1'b0;
        end else if (!stall) begin
            mem.valid <= pipeval;
        end
    end

    // payload follows valid and holds while the memory stage is busy
    always_ff @(posedge clock) begin
        if (!stall) begin
            mem.rd          <= rd;
            mem.need_to_wb  <= need_to_wb;
            mem.alu_op      <= alu_op;
            mem.is_load     <= is_load;
            mem.is_store    <= is_store;
            mem.is_unsigned <= is_unsigned;
            mem.ls_size     <= ls_size;
            mem.src2        <= src2;
            mem.alu_result  <= alu_result;
            mem.ls_address  <= ls_address;
        end
    end

endmodule

// File: lsu_fsm.sv
`timescale 1ns/1ps

module lsu_fsm import backend_pkg::*; #(
    parameter int MEM_INDEX_W = mem_index_w
) (
    input  logic                   clock,
    input  logic                   reset_n,
    mem_stage_if.lsu               mem,

    input  logic                   opload_index_ready,
    input  logic                   opload_operation_done,
    output logic                   opload_index_valid,
    output logic [MEM_INDEX_W-1:0] opload_index,

    input  logic                   opstore_index_ready,
    input  logic                   opstore_operation_done,
    output logic                   opstore_index_valid,
    output logic [MEM_INDEX_W-1:0] opstore_index,

    output logic                   mem_stall
);

    lsu_state_t             state;
    lsu_state_t             state_nxt;
    logic                   mem_access;
    logic                   ready;
    logic                   done;
    logic [MEM_INDEX_W-1:0] index;

    assign mem_access = mem.valid & (mem.is_load | mem.is_store);

    // pick the channel of the current op
    assign ready = mem.is_load ? opload_index_ready : opstore_index_ready;
    assign done  = mem.is_load ? opload_operation_done : opstore_operation_done;

    assign index = mem.ls_address[word_offset_w +: MEM_INDEX_W];

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (mem_access) begin
                    state_nxt = st_req;
                end
            end
            st_req: begin
                if (ready) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (done) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign opload_index_valid  = (state == st_req) & mem.is_load;
    assign opstore_index_valid = (state == st_req) & mem.is_store;
    assign opload_index        = index;    // held stable by the stalled stage register
    assign opstore_index       = index;

    // drops in the done cycle so the op leaves at the next edge
    assign mem_stall = mem_access & ~((state == st_wait) & done);

endmodule

// File: ls_align.sv
`timescale 1ns/1ps

module ls_align import backend_pkg::*; #(
    parameter int XLEN = xlen
) (
    mem_stage_if.align      mem,
    input  logic [XLEN-1:0] opload_read_data,
    output logic [XLEN-1:0] opstore_write_mask,
    output logic [XLEN-1:0] opstore_write_data,
    output logic [XLEN-1:0] load_data
);

    localparam int shamt_w = word_offset_w + 3;

    logic [shamt_w-1:0] shamt;
    logic [XLEN-1:0]    size_mask;
    logic [XLEN-1:0]    rdata;
    logic               sext;

    // byte offset to bit offset
    assign shamt = {mem.ls_address[word_offset_w-1:0], 3'b000};

    always_comb begin
        case (mem.ls_size)
            size_byte:   size_mask = {{(XLEN-8){1'b0}}, {8{1'b1}}};
            size_half:   size_mask = {{(XLEN-16){1'b0}}, {16{1'b1}}};
            size_word:   size_mask = {{(XLEN-32){1'b0}}, {32{1'b1}}};
            default:     size_mask = {XLEN{1'b1}};
        endcase
    end

    assign opstore_write_mask = size_mask << shamt;
    assign opstore_write_data = mem.src2 << shamt;

    // loaded field lands at bit 0 before extension
    assign rdata = opload_read_data >> shamt;

    always_comb begin
        sext = 1'b0;
        case (mem.ls_size)
            size_byte: begin
                sext      = ~mem.is_unsigned & rdata[7];
                load_data = {{(XLEN-8){sext}}, rdata[7:0]};
            end
            size_half: begin
                sext      = ~mem.is_unsigned & rdata[15];
                load_data = {{(XLEN-16){sext}}, rdata[15:0]};
            end
            size_word: begin
                sext      = ~mem.is_unsigned & rdata[31];
                load_data = {{(XLEN-32){sext}}, rdata[31:0]};
            end
            default: begin
                load_data = rdata;
            end
        endcase
    end

endmodule

// File: writeback.sv
`timescale 1ns/1ps

module writeback import backend_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic              clock,
    input  logic              reset_n,
    mem_stage_if.wb           mem,
    input  logic              mem_stall,
    input  logic [XLEN-1:0]   load_data,

    output logic              regfile_write_valid,
    output logic [lreg_w-1:0] regfile_write_rd,
    output logic [XLEN-1:0]   regfile_write_data,
    output logic              commit_valid,

    output logic [lreg_w-1:0] mem_byp_rd,
    output logic              mem_byp_need_to_wb,
    output logic [XLEN-1:0]   mem_byp_result
);

    logic              advance;
    logic [XLEN-1:0]   mem_result;
    logic              wb_valid;
    logic              wb_need_to_wb;
    logic [lreg_w-1:0] wb_rd;
    logic [XLEN-1:0]   wb_result;

    assign advance    = mem.valid & ~mem_stall;
    assign mem_result = mem.is_load ? load_data : mem.alu_result;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid     <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            wb_valid     <= advance;
            commit_valid <= wb_valid;    // one pulse per retired op
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            wb_need_to_wb <= mem.need_to_wb;
            wb_rd         <= mem.rd;
            wb_result     <= mem_result;
        end
    end

    assign regfile_write_valid = wb_valid & wb_need_to_wb;
    assign regfile_write_rd    = wb_rd;
    assign regfile_write_data  = wb_result;

    // load data is only there in the done cycle
    assign mem_byp_rd         = mem.rd;
    assign mem_byp_result     = mem_result;
    assign mem_byp_need_to_wb = mem.valid & mem.need_to_wb
                              & ((mem.alu_op != alu_none) | mem.is_load)
                              & ~(mem.is_load & mem_stall);

endmodule

// File: backend_top.sv
`timescale 1ns/1ps

module backend_top import backend_pkg::*; #(
    parameter int XLEN        = xlen,
    parameter int MEM_INDEX_W = mem_index_w
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   pipeval,
    input  logic [lreg_w-1:0]      rd,
    input  logic [XLEN-1:0]        src1,
    input  logic [XLEN-1:0]        src2,
    input  logic [XLEN-1:0]        imm,
    input  logic                   is_imm,
    input  logic                   need_to_wb,
    input  alu_op_t                alu_op,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   is_unsigned,
    input  ls_size_t               ls_size,

    output logic                   opstore_index_valid,
    output logic [MEM_INDEX_W-1:0] opstore_index,
    input  logic                   opstore_index_ready,
    output logic [XLEN-1:0]        opstore_write_mask,
    output logic [XLEN-1:0]        opstore_write_data,
    input  logic                   opstore_operation_done,

    output logic                   opload_index_valid,
    output logic [MEM_INDEX_W-1:0] opload_index,
    input  logic                   opload_index_ready,
    input  logic [XLEN-1:0]        opload_read_data,
    input  logic                   opload_operation_done,

    output logic                   regfile_write_valid,
    output logic [lreg_w-1:0]      regfile_write_rd,
    output logic [XLEN-1:0]        regfile_write_data,
    output logic                   commit_valid,
    output logic                   mem_stall,

    output logic [lreg_w-1:0]      mem_byp_rd,
    output logic                   mem_byp_need_to_wb,
    output logic [XLEN-1:0]        mem_byp_result
);

    logic [XLEN-1:0] ex_alu_result;
    logic [XLEN-1:0] ex_ls_address;
    logic [XLEN-1:0] load_data;

    mem_stage_if #(.XLEN(XLEN)) mem_if ();

    alu_unit #(.XLEN(XLEN)) u_alu (
        .src1       (src1),
        .src2       (src2),
        .imm        (imm),
        .is_imm     (is_imm),
        .alu_op     (alu_op),
        .alu_result (ex_alu_result),
        .ls_address (ex_ls_address)
    );

    stage_reg #(.XLEN(XLEN)) u_ex2mem (
        .clock       (clock),
        .reset_n     (reset_n),
        .stall       (mem_stall),
        .pipeval     (pipeval),
        .rd          (rd),
        .need_to_wb  (need_to_wb),
        .alu_op      (alu_op),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_unsigned (is_unsigned),
        .ls_size     (ls_size),
        .src2        (src2),
        .alu_result  (ex_alu_result),
        .ls_address  (ex_ls_address),
        .mem         (mem_if.producer)
    );

    lsu_fsm #(.MEM_INDEX_W(MEM_INDEX_W)) u_lsu (
        .clock                  (clock),
        .reset_n                (reset_n),
        .mem                    (mem_if.lsu),
        .opload_index_ready     (opload_index_ready),
        .opload_operation_done  (opload_operation_done),
        .opload_index_valid     (opload_index_valid),
        .opload_index           (opload_index),
        .opstore_index_ready    (opstore_index_ready),
        .opstore_operation_done (opstore_operation_done),
        .opstore_index_valid    (opstore_index_valid),
        .opstore_index          (opstore_index),
        .mem_stall              (mem_stall)
    );

    ls_align #(.XLEN(XLEN)) u_align (
        .mem                (mem_if.align),
        .opload_read_data   (opload_read_data),
        .opstore_write_mask (opstore_write_mask),
        .opstore_write_data (opstore_write_data),
        .load_data          (load_data)
    );

    writeback #(.XLEN(XLEN)) u_wb (
        .clock               (clock),
        .reset_n             (reset_n),
        .mem                 (mem_if.wb),
        .mem_stall           (mem_stall),
        .load_data           (load_data),
        .regfile_write_valid (regfile_write_valid),
        .regfile_write_rd    (regfile_write_rd),
        .regfile_write_data  (regfile_write_data),
        .commit_valid        (commit_valid),
        .mem_byp_rd          (mem_byp_rd),
        .mem_byp_need_to_wb  (mem_byp_need_to_wb),
        .mem_byp_result      (mem_byp_result)
    );

endmodule

// File: tb_backend.sv
`timescale 1ns/1ps

module tb_backend import backend_pkg::*; ();

    localparam int n_alu   = 200;
    localparam int n_mem   = 200;
    localparam int n_mix   = 300;
    // each op costs a request plus ready and done delays and a few bubbles
    localparam int worst_cycles = 12 + (n_alu + n_mem + n_mix) * 12 + 4 * 8;
    localparam int max_cycles   = 4 * worst_cycles;

    logic                   clock;
    logic                   reset_n;
    logic                   pipeval;
    logic [lreg_w-1:0]      rd;
    logic [xlen-1:0]        src1;
    logic [xlen-1:0]        src2;
    logic [xlen-1:0]        imm;
    logic                   is_imm;
    logic                   need_to_wb;
    alu_op_t                alu_op;
    logic                   is_load;
    logic                   is_store;
    logic                   is_unsigned;
    ls_size_t               ls_size;
    logic                   opstore_index_valid;
    logic [mem_index_w-1:0] opstore_index;
    logic                   opstore_index_ready;
    logic [xlen-1:0]        opstore_write_mask;
    logic [xlen-1:0]        opstore_write_data;
    logic                   opstore_operation_done;
    logic                   opload_index_valid;
    logic [mem_index_w-1:0] opload_index;
    logic                   opload_index_ready;
    logic [xlen-1:0]        opload_read_data;
    logic                   opload_operation_done;
    logic                   regfile_write_valid;
    logic [lreg_w-1:0]      regfile_write_rd;
    logic [xlen-1:0]        regfile_write_data;
    logic                   commit_valid;
    logic                   mem_stall;
    logic [lreg_w-1:0]      mem_byp_rd;
    logic                   mem_byp_need_to_wb;
    logic [xlen-1:0]        mem_byp_result;

    integer seed;
    int     cycles;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     issued_count;
    int     commit_count;

    logic [63:0]            mem_model [0:63];
    logic [lreg_w-1:0]      wb_rd_q [$];
    logic [63:0]            wb_data_q [$];
    logic                   acc_store_q [$];
    logic [mem_index_w-1:0] acc_idx_q [$];
    logic [63:0]            acc_mask_q [$];
    logic [63:0]            acc_data_q [$];

    // responder state 0 is idle, 1 waits to give ready and 2 waits to give done
    logic [1:0]             rsp_state;
    int                     rsp_wait;
    logic                   cap_store;
    logic [mem_index_w-1:0] cap_idx;
    logic [63:0]            cap_mask;
    logic [63:0]            cap_data;

    backend_top #(.XLEN(xlen), .MEM_INDEX_W(mem_index_w)) u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        cycles = 0;
        while (cycles <= max_cycles) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("Verification failed");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [63:0] alu_expect(alu_op_t op, logic [63:0] a, logic [63:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 64'd1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};
            alu_sltu: return {63'd0, a < b};
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
            default:  return 64'd0;
        endcase
    endfunction

    // sized field at the byte offset with sign or zero fill above it
    function automatic logic [63:0] load_expect(logic [63:0] word, logic [2:0] off,
                                                ls_size_t size, logic uns);
        logic [63:0] field;
        int          nbits;
        field = word >> (8 * off);
        nbits = 8 << int'(size);
        if (nbits < 64) begin
            if (!uns && field[nbits-1]) begin
                field = field | ({64{1'b1}} << nbits);
            end else begin
                field = field & ~({64{1'b1}} << nbits);
            end
        end
        return field;
    endfunction

    task automatic check_idle_outputs();
        if (opload_index_valid !== 1'b0) begin
            report_mismatch("opload_index_valid", opload_index_valid, 0);
        end
        if (opstore_index_valid !== 1'b0) begin
            report_mismatch("opstore_index_valid", opstore_index_valid, 0);
        end
        if (mem_stall !== 1'b0) begin
            report_mismatch("mem_stall", mem_stall, 0);
        end
        if (regfile_write_valid !== 1'b0) begin
            report_mismatch("regfile_write_valid", regfile_write_valid, 0);
        end
        if (commit_valid !== 1'b0) begin
            report_mismatch("commit_valid", commit_valid, 0);
        end
        if (mem_byp_need_to_wb !== 1'b0) begin
            report_mismatch("mem_byp_need_to_wb", mem_byp_need_to_wb, 0);
        end
    endtask

    task automatic issue_op(input alu_op_t op, input logic load, input logic store,
                            input logic uns, input ls_size_t size, input logic use_imm,
                            input logic [4:0] dest, input logic [63:0] a,
                            input logic [63:0] b, input logic [63:0] k);
        logic [63:0] addr;
        logic [5:0]  shift;
        @(negedge clock);
        pipeval     = 1'b1;
        rd          = dest;
        src1        = a;
        src2        = b;
        imm         = k;
        is_imm      = use_imm;
        need_to_wb  = ~store;
        alu_op      = op;
        is_load     = load;
        is_store    = store;
        is_unsigned = uns;
        ls_size     = size;
        #1;
        while (mem_stall) begin    // hold the op until the stage accepts it
            @(negedge clock);
            #1;
        end
        issued_count++;
        addr  = a + k;
        shift = {addr[2:0], 3'b000};
        if (load || store) begin
            acc_store_q.push_back(store);
            acc_idx_q.push_back(addr[3 +: mem_index_w]);
            acc_mask_q.push_back(({64{1'b1}} >> (64 - (8 << int'(size)))) << shift);
            acc_data_q.push_back(b << shift);
        end
        if (load) begin
            wb_rd_q.push_back(dest);
            wb_data_q.push_back(load_expect(mem_model[addr[8:3]], addr[2:0], size, uns));
        end else if (!store) begin
            wb_rd_q.push_back(dest);
            wb_data_q.push_back(alu_expect(op, a, use_imm ? k : b));
        end
    endtask

    task automatic random_alu_op();
        logic [3:0]  pick;
        logic [11:0] short_imm;
        pick      = $unsigned($random(seed)) % 10;
        short_imm = $random(seed);
        issue_op(alu_op_t'(pick + 4'd1), 1'b0, 1'b0, 1'b0, size_double, $random(seed),
                 $random(seed), {$random(seed), $random(seed)},
                 {$random(seed), $random(seed)}, {{52{short_imm[11]}}, short_imm});
    endtask

    task automatic random_mem_op();
        logic [1:0]  size_bits;
        logic [5:0]  word;
        logic [2:0]  off;
        logic [63:0] base;
        logic [63:0] addr;
        logic        store;
        size_bits = $random(seed);
        word      = $random(seed);
        off       = $random(seed);
        off       = off & (3'b111 << size_bits);    // naturally aligned
        addr      = {55'd0, word, off};
        base      = {$random(seed), $random(seed)};
        store     = $random(seed);
        issue_op(alu_none, ~store, store, $random(seed), ls_size_t'(size_bits), 1'b1,
                 store ? 5'd0 : 5'($random(seed)), base, {$random(seed), $random(seed)},
                 addr - base);
    endtask

    task automatic insert_bubble();
        @(negedge clock);
        pipeval = 1'b0;
        src1    = {$random(seed), $random(seed)};
    endtask

    task automatic drain();
        @(negedge clock);
        pipeval = 1'b0;
        while (commit_count < issued_count) @(negedge clock);
        repeat (4) @(negedge clock);
        if (commit_count != issued_count) begin
            report_mismatch("commit_valid count", commit_count, issued_count);
        end
        if (wb_rd_q.size() != 0) report_error("register writes still expected at end of test");
        if (acc_store_q.size() != 0) report_error("cache accesses still expected at end of test");
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start);
        end
    endtask

    task automatic capture_access();
        cap_store = opstore_index_valid;
        cap_idx   = cap_store ? opstore_index : opload_index;
        cap_mask  = opstore_write_mask;
        cap_data  = opstore_write_data;
        if (acc_store_q.size() == 0) begin
            report_error("index_valid raised with no memory access in flight");
        end else begin
            if (cap_store !== acc_store_q[0]) begin
                report_mismatch("opstore_index_valid", cap_store, acc_store_q[0]);
            end
            if (cap_idx !== acc_idx_q[0]) report_mismatch("index", cap_idx, acc_idx_q[0]);
            if (cap_store && cap_mask !== acc_mask_q[0]) begin
                report_mismatch("opstore_write_mask", cap_mask, acc_mask_q[0]);
            end
            if (cap_store && cap_data !== acc_data_q[0]) begin
                report_mismatch("opstore_write_data", cap_data, acc_data_q[0]);
            end
            void'(acc_store_q.pop_front());
            void'(acc_idx_q.pop_front());
            void'(acc_mask_q.pop_front());
            void'(acc_data_q.pop_front());
        end
    endtask

    task automatic count_down_ready();
        if (rsp_wait == 0) begin
            opload_index_ready  = ~cap_store;
            opstore_index_ready = cap_store;
        end else begin
            rsp_wait--;
        end
    endtask

    task automatic count_down_done();
        if (rsp_wait != 0) begin
            rsp_wait--;
        end else if (cap_store) begin
            mem_model[cap_idx[5:0]] = (mem_model[cap_idx[5:0]] & ~cap_mask)
                                    | (cap_data & cap_mask);
            opstore_operation_done  = 1'b1;
            rsp_state               = 2'd0;
        end else begin
            opload_read_data      = mem_model[cap_idx[5:0]];
            opload_operation_done = 1'b1;
            rsp_state             = 2'd0;
        end
    endtask

    task automatic respond();
        opload_operation_done  = 1'b0;
        opstore_operation_done = 1'b0;
        opload_read_data       = {$random(seed), $random(seed)};    // only valid with done
        if (rsp_state == 2'd0) begin
            if (opload_index_valid || opstore_index_valid) begin
                capture_access();
                rsp_wait  = $unsigned($random(seed)) % 4;
                rsp_state = 2'd1;
                count_down_ready();
            end
        end else if (rsp_state == 2'd1) begin
            if (opload_index_ready || opstore_index_ready) begin
                opload_index_ready  = 1'b0;
                opstore_index_ready = 1'b0;
                if (opload_index_valid || opstore_index_valid) begin
                    report_error("index_valid still high after the accepting edge");
                end
                rsp_wait  = $unsigned($random(seed)) % 4;
                rsp_state = 2'd2;
                count_down_done();
            end else begin
                if (!(cap_store ? opstore_index_valid : opload_index_valid)) begin
                    report_error("index_valid dropped before ready");
                end
                if ((cap_store ? opstore_index : opload_index) !== cap_idx) begin
                    report_error("index changed while waiting for ready");
                end
                if (cap_store && opstore_write_mask !== cap_mask) begin
                    report_error("store mask changed while waiting for ready");
                end
                if (cap_store && opstore_write_data !== cap_data) begin
                    report_error("store data changed while waiting for ready");
                end
                count_down_ready();
            end
        end else begin
            count_down_done();
        end
    endtask

    task automatic check_writeback();
        logic [lreg_w-1:0] exp_rd;
        logic [63:0]       exp_data;
        if (regfile_write_valid) begin
            if (wb_rd_q.size() == 0) begin
                report_error("register write with no retiring micro-op expected");
            end else begin
                exp_rd   = wb_rd_q.pop_front();
                exp_data = wb_data_q.pop_front();
                if (regfile_write_rd !== exp_rd) begin
                    report_mismatch("regfile_write_rd", regfile_write_rd, exp_rd);
                end
                if (regfile_write_data !== exp_data) begin
                    report_mismatch("regfile_write_data", regfile_write_data, exp_data);
                end
            end
        end
    endtask

    task automatic check_bypass();
        if (mem_byp_need_to_wb) begin
            if (wb_rd_q.size() == 0) begin
                report_error("bypass valid with no register write pending");
            end else begin
                if (mem_byp_rd !== wb_rd_q[0]) report_mismatch("mem_byp_rd", mem_byp_rd, wb_rd_q[0]);
                if (mem_byp_result !== wb_data_q[0]) begin
                    report_mismatch("mem_byp_result", mem_byp_result, wb_data_q[0]);
                end
            end
        end
    endtask

    // the writeback stage is popped before the bypass looks at the queue head
    initial begin
        forever begin
            @(negedge clock);
            if (reset_n) begin
                check_writeback();
                if (commit_valid) commit_count++;
                respond();
                #1;
                check_bypass();
            end
        end
    end

    initial begin
        int start;
        seed                   = 22889;
        errors                 = 0;
        tests_run              = 0;
        tests_failed           = 0;
        issued_count           = 0;
        commit_count           = 0;
        rsp_state              = 2'd0;
        rsp_wait               = 0;
        reset_n                = 1'b0;
        pipeval                = 1'b0;
        rd                     = '0;
        src1                   = '0;
        src2                   = '0;
        imm                    = '0;
        is_imm                 = 1'b0;
        need_to_wb             = 1'b0;
        alu_op                 = alu_none;
        is_load                = 1'b0;
        is_store               = 1'b0;
        is_unsigned            = 1'b0;
        ls_size                = size_byte;
        opstore_index_ready    = 1'b0;
        opstore_operation_done = 1'b0;
        opload_index_ready     = 1'b0;
        opload_read_data       = '0;
        opload_operation_done  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = {16'(i), 16'(~i), 16'(i * 7), 16'(i ^ 16'h5a5a)};
        end

        start = errors;
        repeat (10) @(negedge clock);
        check_idle_outputs();
        reset_n = 1'b1;
        @(negedge clock);
        check_idle_outputs();
        report_test("reset_state", start);

        start = errors;
        for (int i = 0; i < n_alu; i++) begin
            random_alu_op();
            if (($random(seed) & 7) == 0) insert_bubble();
        end
        drain();
        report_test("alu_random", start);

        start = errors;
        for (int i = 0; i < n_mem; i++) begin
            random_mem_op();
        end
        drain();
        report_test("load_store_random", start);

        start = errors;
        for (int i = 0; i < n_mix; i++) begin
            if ($random(seed) & 1) random_alu_op();
            else random_mem_op();
            if (($random(seed) & 7) == 0) insert_bubble();
        end
        drain();
        report_test("mixed_backpressure", start);

        $display("tests %0d, failed tests %0d, errors %0d, commits %0d",
                 tests_run, tests_failed, errors, commit_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
backend_pkg.sv
mem_stage_if.sv
alu_unit.sv
stage_reg.sv
lsu_fsm.sv
ls_align.sv
writeback.sv
backend_top.sv
tb_backend.sv
